// File: design/clock_pkg.sv
package clock_pkg;

	// sys_clk cycles per second, 25 for simulation only
	localparam int TICKS_PER_SEC = 25;
	localparam int PRESC_W = (TICKS_PER_SEC > 2) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(TICKS_PER_SEC - 1);

	// blink half period in cycles
	localparam int FLASH_HALF = 8;
	localparam int FLASH_W = $clog2(FLASH_HALF + 1);
	localparam logic [FLASH_W-1:0] FLASH_LAST = FLASH_W'(FLASH_HALF - 1);

	localparam logic [7:0] BLANK_CODE = 8'hff;	// not a legal bcd pair

	// field limits, binary
	localparam logic [7:0] SEC_MAX = 8'd59;
	localparam logic [7:0] MIN_MAX = 8'd59;
	localparam logic [7:0] HOUR_MAX = 8'd23;

	typedef enum logic [1:0] {
		MODE_RUN = 2'd0,
		MODE_SET_MIN = 2'd1,
		MODE_SET_HOUR = 2'd2
	} adjust_mode_t;

	// one step per cycle at most, inc and dec never both set
	typedef struct packed {
		adjust_mode_t mode;
		logic inc;
		logic dec;
	} adjust_cmd_t;

	// raw counter values
	typedef struct packed {
		logic [7:0] hour;
		logic [7:0] min;
		logic [7:0] sec;
	} time_bin_t;

	// two bcd digits per field, hour in the top byte
	typedef struct packed {
		logic [7:0] hour;
		logic [7:0] min;
		logic [7:0] sec;
	} display_t;

endpackage

// File: design/adjust_ctrl.sv
`timescale 1ns/1ns

module adjust_ctrl (
	input logic sys_clk,
	input logic rst,
	input logic key_adjust_flag,
	input logic key_add_flag,
	input logic key_sub_flag,

	output clock_pkg::adjust_cmd_t cmd
);

	clock_pkg::adjust_mode_t mode_next;
	logic step_ok;
	logic add_step;
	logic sub_step;

	// run -> set min -> set hour -> run
	always_comb begin
		mode_next = cmd.mode;
		if (key_adjust_flag) begin
			case (cmd.mode)
				clock_pkg::MODE_RUN: mode_next = clock_pkg::MODE_SET_MIN;
				clock_pkg::MODE_SET_MIN: mode_next = clock_pkg::MODE_SET_HOUR;
				default: mode_next = clock_pkg::MODE_RUN;
			endcase
		end
	end

	// a step pressed with adjust would land on the wrong field, drop it
	assign step_ok = (cmd.mode != clock_pkg::MODE_RUN) && !key_adjust_flag;

	// add and sub together cancel out
	assign add_step = step_ok && key_add_flag && !key_sub_flag;
	assign sub_step = step_ok && key_sub_flag && !key_add_flag;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			cmd.mode <= clock_pkg::MODE_RUN;
			cmd.inc <= 1'b0;
			cmd.dec <= 1'b0;
		end else begin
			cmd.mode <= mode_next;
			cmd.inc <= add_step;	// one cycle pulse
			cmd.dec <= sub_step;
		end
	end

endmodule

// File: design/sec_timebase.sv
`timescale 1ns/1ns

module sec_timebase (
	input logic sys_clk,
	input logic rst,

	output logic [7:0] sec,
	output logic min_tick
);

	logic [clock_pkg::PRESC_W-1:0] presc;
	logic sec_tick;

	// last cycle of each second
	assign sec_tick = (presc == clock_pkg::PRESC_LAST);

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			presc <= '0;
		end else if (sec_tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sec <= '0;
		end else if (sec_tick) begin
			if (sec == clock_pkg::SEC_MAX)
				sec <= '0;
			else
				sec <= sec + 8'd1;
		end
	end

	// high together with the 59 -> 0 edge
	assign min_tick = sec_tick && (sec == clock_pkg::SEC_MAX);

endmodule

// File: design/hm_counter.sv
`timescale 1ns/1ns

module hm_counter (
	input logic sys_clk,
	input logic rst,
	input logic min_tick,
	input clock_pkg::adjust_cmd_t cmd,

	output logic [7:0] min,
	output logic [7:0] hour
);

	logic min_inc;
	logic min_dec;
	logic hour_inc;
	logic hour_dec;
	logic hour_carry;
	logic [1:0] min_up;
	logic [1:0] hour_up;
	logic [7:0] min_next;
	logic [7:0] hour_next;

	// val + up - down, modulo max+1
	// up is at most 2, so one subtract covers the overflow
	function automatic logic [7:0] step_field(
		input logic [7:0] val,
		input logic [7:0] max,
		input logic [1:0] up,
		input logic down
	);
		logic [8:0] sum;
		sum = {1'b0, val} + {7'b0, up};
		if (sum > {1'b0, max})
			sum = sum - ({1'b0, max} + 9'd1);
		if (down) begin
			if (sum == 9'd0)
				sum = {1'b0, max};
			else
				sum = sum - 9'd1;
		end
		return sum[7:0];
	endfunction

	// adjust steps only reach the selected field
	assign min_inc = cmd.inc && (cmd.mode == clock_pkg::MODE_SET_MIN);
	assign min_dec = cmd.dec && (cmd.mode == clock_pkg::MODE_SET_MIN);
	assign hour_inc = cmd.inc && (cmd.mode == clock_pkg::MODE_SET_HOUR);
	assign hour_dec = cmd.dec && (cmd.mode == clock_pkg::MODE_SET_HOUR);

	// hour carry from minute rollover only, never from a step
	assign hour_carry = min_tick && (min == clock_pkg::MIN_MAX);

	assign min_up = {1'b0, min_tick} + {1'b0, min_inc};
	assign hour_up = {1'b0, hour_carry} + {1'b0, hour_inc};

	assign min_next = step_field(min, clock_pkg::MIN_MAX, min_up, min_dec);
	assign hour_next = step_field(hour, clock_pkg::HOUR_MAX, hour_up, hour_dec);

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			min <= '0;
			hour <= '0;
		end else begin
			min <= min_next;
			hour <= hour_next;
		end
	end

endmodule

// File: design/display_format.sv
`timescale 1ns/1ns

module display_format (
	input logic sys_clk,
	input logic rst,
	input clock_pkg::time_bin_t time_in,
	input clock_pkg::adjust_mode_t mode,

	output clock_pkg::display_t show_data
);

	logic [clock_pkg::FLASH_W-1:0] flash_cnt;
	logic flash_off;
	clock_pkg::adjust_mode_t mode_q;
	logic mode_chg;
	logic blank;
	clock_pkg::display_t word_d;

	// fields stay below 100, two digits are enough
	function automatic logic [7:0] bin2bcd(input logic [7:0] bin);
		logic [7:0] tens;
		logic [7:0] ones;
		tens = bin / 8'd10;
		ones = bin % 8'd10;
		return {tens[3:0], ones[3:0]};
	endfunction

	assign mode_chg = (mode != mode_q);

	// blink phase, restarts "on" at every mode change
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			flash_cnt <= '0;
			flash_off <= 1'b0;
			mode_q <= clock_pkg::MODE_RUN;
		end else begin
			mode_q <= mode;
			if (mode_chg || mode == clock_pkg::MODE_RUN) begin
				flash_cnt <= '0;
				flash_off <= 1'b0;
			end else if (flash_cnt == clock_pkg::FLASH_LAST) begin
				flash_cnt <= '0;
				flash_off <= ~flash_off;
			end else begin
				flash_cnt <= flash_cnt + 1'b1;
			end
		end
	end

	// stale phase of the old mode must not show
	assign blank = flash_off && !mode_chg;

	always_comb begin
		word_d.hour = bin2bcd(time_in.hour);
		word_d.min = bin2bcd(time_in.min);
		word_d.sec = bin2bcd(time_in.sec);
		if (blank) begin
			case (mode)
				clock_pkg::MODE_SET_MIN: word_d.min = clock_pkg::BLANK_CODE;
				clock_pkg::MODE_SET_HOUR: word_d.hour = clock_pkg::BLANK_CODE;
				default: ;	// run, nothing blinks
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst)
			show_data <= '0;
		else
			show_data <= word_d;
	end

endmodule

// File: design/clock_top.sv
`timescale 1ns/1ns

module clock_top (
	input logic sys_clk,
	input logic rst,
	input logic key_adjust_flag,
	input logic key_add_flag,
	input logic key_sub_flag,

	output clock_pkg::display_t show_data
);

	clock_pkg::adjust_cmd_t cmd;
	clock_pkg::time_bin_t time_bin;
	logic [7:0] sec;
	logic [7:0] min;
	logic [7:0] hour;
	logic min_tick;

	adjust_ctrl adjust_ctrl_i (
		.sys_clk			(sys_clk),
		.rst				(rst),
		.key_adjust_flag	(key_adjust_flag),
		.key_add_flag		(key_add_flag),
		.key_sub_flag		(key_sub_flag),
		.cmd				(cmd)
	);

	sec_timebase sec_timebase_i (
		.sys_clk			(sys_clk),
		.rst				(rst),
		.sec				(sec),
		.min_tick			(min_tick)
	);

	hm_counter hm_counter_i (
		.sys_clk			(sys_clk),
		.rst				(rst),
		.min_tick			(min_tick),
		.cmd				(cmd),
		.min				(min),
		.hour				(hour)
	);

	assign time_bin = '{hour: hour, min: min, sec: sec};

	display_format display_format_i (
		.sys_clk			(sys_clk),
		.rst				(rst),
		.time_in			(time_bin),
		.mode				(cmd.mode),
		.show_data			(show_data)
	);

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 20;	// 40 ns period

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

// File: test/clock_top_tb.sv
`timescale 1ns/1ns

module clock_top_tb;

	localparam int TPS = clock_pkg::TICKS_PER_SEC;
	localparam int FH = clock_pkg::FLASH_HALF;
	localparam int RESET_CYCLES = 16;
	localparam int COUNT_CYCLES = 70 * TPS;
	localparam int ROLL_CYCLES = 62 * TPS;	// longest wait for midnight
	localparam int TEST_CYCLES = RESET_CYCLES + COUNT_CYCLES + 150 + (16 * TPS + ROLL_CYCLES)
		+ (16 * FH + 60) + (2 * TPS + 150);
	localparam int TIMEOUT_CYCLES = (TEST_CYCLES * 5) / 4;

	logic sys_clk;
	logic rst;
	logic key_adjust_flag;
	logic key_add_flag;
	logic key_sub_flag;
	clock_pkg::display_t show_data;

	// time model
	clock_pkg::adjust_mode_t m_mode;
	logic m_inc;
	logic m_dec;
	int m_presc;
	int m_sec;
	int m_min;
	int m_hour;
	clock_pkg::display_t exp_show;
	clock_pkg::adjust_mode_t exp_sel;	// mode the display saw

	clock_pkg::adjust_mode_t prev_sel;
	int on_run;
	int blank_run;
	int cycles;
	int errors;
	int checks;

	tb_clk_gen clk_gen_i (
		.clk	(sys_clk)
	);

	clock_top clock_top_i (
		.sys_clk			(sys_clk),
		.rst				(rst),
		.key_adjust_flag	(key_adjust_flag),
		.key_add_flag		(key_add_flag),
		.key_sub_flag		(key_sub_flag),
		.show_data			(show_data)
	);

	function automatic logic [7:0] to_bcd(input int v);
		return 8'((v / 10) * 16 + (v % 10));
	endfunction

	always @(posedge sys_clk) begin
		bit sec_wrap;
		bit min_wrap;
		bit hour_carry;
		int min_step;
		int hour_step;
		if (rst) begin
			m_mode = clock_pkg::MODE_RUN;
			m_inc = 1'b0;
			m_dec = 1'b0;
			m_presc = 0;
			m_sec = 0;
			m_min = 0;
			m_hour = 0;
			exp_show = '0;
			exp_sel = clock_pkg::MODE_RUN;
		end else begin
			exp_show.hour = to_bcd(m_hour);	// output register, one cycle behind
			exp_show.min = to_bcd(m_min);
			exp_show.sec = to_bcd(m_sec);
			exp_sel = m_mode;
			sec_wrap = (m_presc == TPS - 1);
			min_wrap = sec_wrap && (m_sec == 59);
			hour_carry = min_wrap && (m_min == 59);
			min_step = 0;
			hour_step = 0;
			if (m_mode == clock_pkg::MODE_SET_MIN)
				min_step = int'(m_inc) - int'(m_dec);
			else if (m_mode == clock_pkg::MODE_SET_HOUR)
				hour_step = int'(m_inc) - int'(m_dec);
			m_presc = sec_wrap ? 0 : m_presc + 1;
			m_sec = sec_wrap ? (m_sec + 1) % 60 : m_sec;
			m_min = (m_min + int'(min_wrap) + min_step + 60) % 60;
			m_hour = (m_hour + int'(hour_carry) + hour_step + 24) % 24;
			// steps only in a set mode, never with adjust or with both keys
			m_inc = (m_mode != clock_pkg::MODE_RUN) && !key_adjust_flag
				&& key_add_flag && !key_sub_flag;
			m_dec = (m_mode != clock_pkg::MODE_RUN) && !key_adjust_flag
				&& key_sub_flag && !key_add_flag;
			if (key_adjust_flag) begin
				case (m_mode)
					clock_pkg::MODE_RUN: m_mode = clock_pkg::MODE_SET_MIN;
					clock_pkg::MODE_SET_MIN: m_mode = clock_pkg::MODE_SET_HOUR;
					default: m_mode = clock_pkg::MODE_RUN;
				endcase
			end
		end
	end

	task automatic check_field(input string name, input logic [7:0] got,
		input logic [7:0] exp, input logic may_blank);
		checks++;
		assert (got === exp || (may_blank && got === clock_pkg::BLANK_CODE)) else begin
			errors++;
			$display("** Error: show_data.%s expected %h, got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic track_blink();
		logic [7:0] sel_field;
		if (exp_sel != prev_sel) begin
			on_run = 0;
			blank_run = 0;
		end
		prev_sel = exp_sel;
		if (exp_sel != clock_pkg::MODE_RUN) begin
			sel_field = (exp_sel == clock_pkg::MODE_SET_HOUR) ? show_data.hour : show_data.min;
			if (sel_field === clock_pkg::BLANK_CODE) begin
				blank_run++;
				on_run = 0;
			end else begin
				on_run++;
				blank_run = 0;
			end
			checks += 2;
			assert (on_run < 2 * FH) else begin
				errors++;
				$display("selected field not blanked for %0d cycles at %0t", on_run, $time);
			end
			assert (blank_run <= FH) else begin
				errors++;
				$display("selected field blank for %0d cycles at %0t", blank_run, $time);
			end
		end
	endtask

	// outputs settled, sample mid cycle
	always @(negedge sys_clk) begin
		if (cycles > 0) begin
			check_field("hour", show_data.hour, exp_show.hour, exp_sel == clock_pkg::MODE_SET_HOUR);
			check_field("min", show_data.min, exp_show.min, exp_sel == clock_pkg::MODE_SET_MIN);
			check_field("sec", show_data.sec, exp_show.sec, 1'b0);
			track_blink();
		end
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("errors: %0d, checks: %0d", errors, checks);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic gap();
		idle(3 + int'($urandom % 5));
	endtask

	task automatic press(input logic adj, input logic add, input logic sub);
		next_cycle();
		key_adjust_flag = adj;
		key_add_flag = add;
		key_sub_flag = sub;
		next_cycle();
		key_adjust_flag = 1'b0;
		key_add_flag = 1'b0;
		key_sub_flag = 1'b0;
	endtask

	task automatic wait_for_midnight();
		int n;
		n = 0;
		while (show_data !== '0 && n < ROLL_CYCLES) begin
			next_cycle();
			n++;
		end
		checks++;
		if (show_data !== '0) begin
			errors++;
			$display("day rollover to 00:00:00 not seen within %0d cycles", ROLL_CYCLES);
		end
	endtask

	initial begin
		void'($urandom(32'ha5bb_a978));
		rst = 1'b1;
		key_adjust_flag = 1'b0;
		key_add_flag = 1'b0;
		key_sub_flag = 1'b0;
		prev_sel = clock_pkg::MODE_RUN;
		on_run = 0;
		blank_run = 0;
		cycles = 0;
		errors = 0;
		checks = 0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1 rst = 1'b0;

		idle(COUNT_CYCLES);	// 70 s of counting

		// minute and hour wrap in both directions
		press(1'b1, 1'b0, 1'b0);
		gap();
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b0, 1'b1, 1'b0);
		gap();
		press(1'b1, 1'b0, 1'b0);
		gap();
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b0, 1'b1, 1'b0);
		gap();
		press(1'b1, 1'b0, 1'b0);
		gap();

		// 23:59 then midnight
		while (m_sec > 45)
			next_cycle();
		press(1'b1, 1'b0, 1'b0);
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b1, 1'b0, 1'b0);
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b1, 1'b0, 1'b0);
		wait_for_midnight();

		// blinking in each set mode
		press(1'b1, 1'b0, 1'b0);
		idle(6 * FH);
		press(1'b1, 1'b0, 1'b0);
		idle(6 * FH);
		press(1'b1, 1'b0, 1'b0);
		idle(4 * FH);

		// keys that must do nothing
		press(1'b0, 1'b1, 1'b0);
		gap();
		press(1'b0, 1'b0, 1'b1);
		gap();
		press(1'b1, 1'b0, 1'b0);
		gap();
		press(1'b0, 1'b1, 1'b1);
		gap();
		press(1'b1, 1'b0, 1'b0);
		gap();
		press(1'b0, 1'b1, 1'b1);
		gap();
		press(1'b1, 1'b0, 1'b0);
		idle(2 * TPS);

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: clock_top.f
design/clock_pkg.sv
design/adjust_ctrl.sv
design/sec_timebase.sv
design/hm_counter.sv
design/display_format.sv
design/clock_top.sv
test/tb_clk_gen.sv
test/clock_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the clock testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f clock_top.f \
	--top-module clock_top_tb \
	-o sim_clock_top

./obj_dir/sim_clock_top | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
